/* hdl/loader_pkg.sv */
package loader_pkg;

	// ==================================================
	// Vector types
	// ==================================================

	typedef logic [7:0]  byte_t;
	typedef logic [15:0] word16_t;
	typedef logic [24:0] mem_addr_t;
	typedef logic [7:0]  dl_index_t;

	// ==================================================
	// Download kinds and CRT layout
	// ==================================================

	localparam dl_index_t IDX_PRG = 8'd4;
	localparam dl_index_t IDX_CRT = 8'd5;
	localparam dl_index_t IDX_TAP = 8'd6;

	// Chip packets follow the 64 byte cartridge header
	localparam mem_addr_t CRT_CHIP_START = 25'h40;

	// ==================================================
	// BASIC pointers in zero page
	// ==================================================

	// Start of BASIC text, $0801 after reset
	localparam byte_t PTR_TXT_LO  = 8'h2B;
	localparam byte_t PTR_TXT_HI  = 8'h2C;

	// SAVE start, left at zero
	localparam byte_t PTR_SAVE_LO = 8'hAC;
	localparam byte_t PTR_SAVE_HI = 8'hAD;

	// VAR, ARY, STR and LOAD_END all point past the loaded program
	localparam byte_t [3:0] PTR_END_LO_SET = {8'h2D, 8'h2F, 8'h31, 8'hAE};
	localparam byte_t [3:0] PTR_END_HI_SET = {8'h2E, 8'h30, 8'h32, 8'hAF};

	// Zero page walk stops here
	localparam mem_addr_t MEMINIT_LIMIT = 25'h100;

	// ==================================================
	// Load sequencer states
	// ==================================================

	typedef enum logic [1:0] {
		IDLE,
		LOADING,
		MEMINIT,
		START
	} seq_state_t;

endpackage

/* hdl/mem_slot_if.sv */
`timescale 1ns/10ps

interface mem_slot_if;
	import loader_pkg::*;

	// One write waiting for an io cycle slot
	logic      wr_pend;
	mem_addr_t wr_addr;
	byte_t     wr_data;

	// Pulses once when the slot writer launches the write
	logic      wr_taken;

	modport seq (
		output wr_pend,
		output wr_addr,
		output wr_data,
		input  wr_taken
	);

	modport slot (
		input  wr_pend,
		input  wr_addr,
		input  wr_data,
		output wr_taken
	);

endinterface

/* hdl/crt_header_regs.sv */
`timescale 1ns/10ps

module crt_header_regs (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  ioctl_download_i,
	input  logic                  ioctl_wr_i,
	input  loader_pkg::dl_index_t ioctl_index_i,
	input  loader_pkg::mem_addr_t ioctl_addr_i,
	input  loader_pkg::byte_t     ioctl_data_i,
	input  logic                  detach_i,
	output logic                  crt_align_o,
	output logic                  crt_payload_o,
	output logic                  cart_attached_o,
	output logic                  crt_hdr_wr_o,
	output loader_pkg::word16_t   cart_id_o,
	output loader_pkg::byte_t     cart_exrom_o,
	output loader_pkg::byte_t     cart_game_o,
	output loader_pkg::word16_t   bank_num_o,
	output loader_pkg::word16_t   bank_laddr_o,
	output loader_pkg::word16_t   bank_size_o,
	output loader_pkg::byte_t     bank_type_o
);
	import loader_pkg::*;

	// File header offsets, fields are big endian
	localparam mem_addr_t OFS_ID_HI = 25'h16;
	localparam mem_addr_t OFS_ID_LO = 25'h17;
	localparam mem_addr_t OFS_EXROM = 25'h18;
	localparam mem_addr_t OFS_GAME  = 25'h19;

	logic        load_crt;
	logic        chip_byte;
	logic        hdr_byte;
	logic [3:0]  hdr_cnt;
	logic [31:0] blk_len;
	logic        dl_d;
	logic        detach_d;

	assign load_crt  = (ioctl_index_i == IDX_CRT);
	assign chip_byte = ioctl_wr_i && load_crt && (ioctl_addr_i >= CRT_CHIP_START);
	assign hdr_byte  = chip_byte && (hdr_cnt != 4'd0);

	// Block used up: the next byte opens a new chip packet
	assign crt_align_o   = chip_byte && (blk_len == '0) && (hdr_cnt == 4'd0);
	assign crt_payload_o = chip_byte && (blk_len != '0) && (hdr_cnt == 4'd0);

	// ==================================================
	// Chip packet tracking and attach state
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			hdr_cnt         <= 4'd0;
			blk_len         <= '0;
			crt_hdr_wr_o    <= 1'b0;
			cart_attached_o <= 1'b0;
			dl_d            <= 1'b0;
			detach_d        <= 1'b0;
		end else begin
			dl_d         <= ioctl_download_i;
			detach_d     <= detach_i;
			crt_hdr_wr_o <= 1'b0;

			if (ioctl_wr_i && load_crt && (ioctl_addr_i == '0)) begin
				hdr_cnt <= 4'd0;
				blk_len <= '0;
			end

			if (crt_align_o) begin
				hdr_cnt <= 4'd1;
			end else if (hdr_byte) begin
				// Counter wraps to zero after byte 15
				hdr_cnt <= hdr_cnt + 4'd1;
				case (hdr_cnt)
					4'd4:  blk_len[31:24] <= ioctl_data_i;
					4'd5:  blk_len[23:16] <= ioctl_data_i;
					4'd6:  blk_len[15:8]  <= ioctl_data_i;
					4'd7:  blk_len[7:0]   <= ioctl_data_i;
					4'd8:  blk_len        <= blk_len - 32'd16;
					4'd15: crt_hdr_wr_o   <= 1'b1;
					default: ;
				endcase
			end else if (crt_payload_o) begin
				blk_len <= blk_len - 32'd1;
			end

			// Attached once a CRT download has completed
			if (load_crt && (dl_d != ioctl_download_i))
				cart_attached_o <= dl_d;
			if (detach_i && !detach_d)
				cart_attached_o <= 1'b0;
		end
	end

	// ==================================================
	// Header fields
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (ioctl_wr_i && load_crt) begin
			case (ioctl_addr_i)
				OFS_ID_HI: cart_id_o[15:8] <= ioctl_data_i;
				OFS_ID_LO: cart_id_o[7:0]  <= ioctl_data_i;
				OFS_EXROM: cart_exrom_o    <= ioctl_data_i;
				OFS_GAME:  cart_game_o     <= ioctl_data_i;
				default: ;
			endcase
		end

		if (hdr_byte) begin
			case (hdr_cnt)
				4'd9:  bank_type_o        <= ioctl_data_i;
				4'd10: bank_num_o[15:8]   <= ioctl_data_i;
				4'd11: bank_num_o[7:0]    <= ioctl_data_i;
				4'd12: bank_laddr_o[15:8] <= ioctl_data_i;
				4'd13: bank_laddr_o[7:0]  <= ioctl_data_i;
				4'd14: bank_size_o[15:8]  <= ioctl_data_i;
				4'd15: bank_size_o[7:0]   <= ioctl_data_i;
				default: ;
			endcase
		end
	end

endmodule

/* hdl/load_sequencer.sv */
`timescale 1ns/10ps

module load_sequencer #(
	parameter loader_pkg::mem_addr_t CRT_BASE = 25'h100000,
	parameter loader_pkg::mem_addr_t TAP_BASE = 25'h200000
) (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  ioctl_download_i,
	input  logic                  ioctl_wr_i,
	input  loader_pkg::dl_index_t ioctl_index_i,
	input  loader_pkg::mem_addr_t ioctl_addr_i,
	input  loader_pkg::byte_t     ioctl_data_i,
	input  logic                  crt_align_i,
	input  logic                  crt_payload_i,
	mem_slot_if.seq               slot_if,
	output logic                  ioctl_wait_o,
	output logic                  start_o,
	output loader_pkg::mem_addr_t tap_len_o
);
	import loader_pkg::*;

	seq_state_t state;
	mem_addr_t  load_addr;
	mem_addr_t  req_addr;
	word16_t    inj_end;
	logic [8:0] rule;
	logic       load_prg;
	logic       prg_byte;
	logic       crt_byte;
	logic       tap_byte;
	logic       host_req;
	logic       mi_active;
	logic       mi_done;
	logic       mi_write;

	// Pointer value for a zero page address, bit 8 flags a hit
	function automatic logic [8:0] ptr_rule(input byte_t a, input word16_t end_addr);
		logic [8:0] r;
		r = '0;
		if (a == PTR_TXT_LO)
			r = {1'b1, 8'h01};
		else if (a == PTR_TXT_HI)
			r = {1'b1, 8'h08};
		else if ((a == PTR_SAVE_LO) || (a == PTR_SAVE_HI))
			r = {1'b1, 8'h00};
		for (int i = 0; i < 4; i++) begin
			if (a == PTR_END_LO_SET[i])
				r = {1'b1, end_addr[7:0]};
			if (a == PTR_END_HI_SET[i])
				r = {1'b1, end_addr[15:8]};
		end
		return r;
	endfunction

	// ==================================================
	// Request decode
	// ==================================================

	assign load_prg = (ioctl_index_i == IDX_PRG);
	assign prg_byte = ioctl_wr_i && ioctl_download_i && load_prg;
	assign crt_byte = ioctl_wr_i && ioctl_download_i && (ioctl_index_i == IDX_CRT);
	assign tap_byte = ioctl_wr_i && ioctl_download_i && (ioctl_index_i == IDX_TAP);

	// First two PRG bytes are the load address
	assign host_req = (prg_byte && (ioctl_addr_i > 25'd1)) ||
	                  (crt_byte && crt_payload_i) || tap_byte;

	// Tape image always restarts at its region base
	assign req_addr = (tap_byte && (ioctl_addr_i == '0)) ? TAP_BASE : load_addr;

	assign rule      = ptr_rule(load_addr[7:0], inj_end);
	assign mi_active = (state == MEMINIT) && !slot_if.wr_pend;
	assign mi_done   = mi_active && (load_addr == MEMINIT_LIMIT);
	assign mi_write  = mi_active && !mi_done && rule[8];

	assign ioctl_wait_o = slot_if.wr_pend || (state == MEMINIT);

	// ==================================================
	// Sequencer FSM and write handshake
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state           <= IDLE;
			slot_if.wr_pend <= 1'b0;
			start_o         <= 1'b0;
			tap_len_o       <= '0;
		end else begin
			start_o <= 1'b0;

			if (slot_if.wr_taken)
				slot_if.wr_pend <= 1'b0;
			if (host_req || mi_write)
				slot_if.wr_pend <= 1'b1;

			// Length is one past the last offset, plus one spare byte
			if (tap_byte)
				tap_len_o <= ioctl_addr_i + 25'd2;

			case (state)
				IDLE: begin
					if (ioctl_download_i)
						state <= LOADING;
				end
				LOADING: begin
					if (!ioctl_download_i)
						state <= load_prg ? MEMINIT : IDLE;
				end
				MEMINIT: begin
					if (mi_done)
						state <= START;
				end
				START: begin
					start_o <= 1'b1;
					state   <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// ==================================================
	// Load address, end pointer and write payload
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (prg_byte) begin
			if (ioctl_addr_i == '0) begin
				load_addr     <= mem_addr_t'(ioctl_data_i);
				inj_end[7:0]  <= ioctl_data_i;
			end else if (ioctl_addr_i == 25'd1) begin
				load_addr[15:8] <= ioctl_data_i;
				inj_end[15:8]   <= ioctl_data_i;
			end else begin
				inj_end <= inj_end + 16'd1;
			end
		end

		if (crt_byte && (ioctl_addr_i == '0))
			load_addr <= CRT_BASE;

		// Each chip starts on an 8 KB boundary
		if (crt_align_i && (load_addr[12:0] != '0))
			load_addr <= {load_addr[24:13] + 12'd1, 13'd0};

		if (host_req) begin
			slot_if.wr_addr <= req_addr;
			slot_if.wr_data <= ioctl_data_i;
			load_addr       <= req_addr + 25'd1;
		end

		// Zero page walk
		if ((state == LOADING) && !ioctl_download_i)
			load_addr <= '0;
		if (mi_write) begin
			slot_if.wr_addr <= load_addr;
			slot_if.wr_data <= rule[7:0];
		end
		if (mi_active && !mi_done)
			load_addr <= load_addr + 25'd1;
	end

endmodule

/* hdl/io_slot_writer.sv */
`timescale 1ns/10ps

module io_slot_writer (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  io_cycle_i,
	mem_slot_if.slot              slot_if,
	output logic                  mem_ce_o,
	output logic                  mem_we_o,
	output loader_pkg::mem_addr_t mem_addr_o,
	output loader_pkg::byte_t     mem_data_o
);

	logic io_cycle_d;
	logic slot_open;
	logic slot_close;
	logic launch;

	// Slot begins on the falling edge of io_cycle
	assign slot_open  = io_cycle_d && !io_cycle_i;
	// Two cycles high ends the strobe
	assign slot_close = io_cycle_d && io_cycle_i;
	assign launch     = slot_open && slot_if.wr_pend;

	// ==================================================
	// Strobes and acknowledge
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			io_cycle_d       <= 1'b0;
			mem_ce_o         <= 1'b0;
			mem_we_o         <= 1'b0;
			slot_if.wr_taken <= 1'b0;
		end else begin
			io_cycle_d       <= io_cycle_i;
			slot_if.wr_taken <= launch;
			if (launch) begin
				mem_ce_o <= 1'b1;
				mem_we_o <= 1'b1;
			end else if (slot_close) begin
				mem_ce_o <= 1'b0;
				mem_we_o <= 1'b0;
			end
		end
	end

	// Address and data held for the whole slot
	always_ff @(posedge clk_sys) begin
		if (launch) begin
			mem_addr_o <= slot_if.wr_addr;
			mem_data_o <= slot_if.wr_data;
		end
	end

endmodule

/* hdl/c64_loader_top.sv */
`timescale 1ns/10ps

module c64_loader_top #(
	parameter loader_pkg::mem_addr_t CRT_BASE = 25'h100000,
	parameter loader_pkg::mem_addr_t TAP_BASE = 25'h200000
) (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  ioctl_download_i,
	input  logic                  ioctl_wr_i,
	input  logic                  io_cycle_i,
	input  loader_pkg::dl_index_t ioctl_index_i,
	input  loader_pkg::mem_addr_t ioctl_addr_i,
	input  loader_pkg::byte_t     ioctl_data_i,
	input  logic                  detach_i,
	output logic                  ioctl_wait_o,
	output logic                  mem_ce_o,
	output logic                  mem_we_o,
	output logic                  start_o,
	output logic                  cart_attached_o,
	output logic                  crt_hdr_wr_o,
	output loader_pkg::mem_addr_t mem_addr_o,
	output loader_pkg::byte_t     mem_data_o,
	output loader_pkg::word16_t   cart_id_o,
	output loader_pkg::word16_t   bank_num_o,
	output loader_pkg::word16_t   bank_laddr_o,
	output loader_pkg::word16_t   bank_size_o,
	output loader_pkg::byte_t     cart_exrom_o,
	output loader_pkg::byte_t     cart_game_o,
	output loader_pkg::byte_t     bank_type_o,
	output loader_pkg::mem_addr_t tap_len_o
);

	logic crt_align;
	logic crt_payload;

	// Pending write between sequencer and slot writer
	mem_slot_if u_slot_if ();

	// ==================================================
	// CRT header capture
	// ==================================================

	crt_header_regs u_crt_header_regs (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.detach_i         (detach_i),
		.crt_align_o      (crt_align),
		.crt_payload_o    (crt_payload),
		.cart_attached_o  (cart_attached_o),
		.crt_hdr_wr_o     (crt_hdr_wr_o),
		.cart_id_o        (cart_id_o),
		.cart_exrom_o     (cart_exrom_o),
		.cart_game_o      (cart_game_o),
		.bank_num_o       (bank_num_o),
		.bank_laddr_o     (bank_laddr_o),
		.bank_size_o      (bank_size_o),
		.bank_type_o      (bank_type_o)
	);

	// ==================================================
	// Load sequencing and memory slot
	// ==================================================

	load_sequencer #(
		.CRT_BASE (CRT_BASE),
		.TAP_BASE (TAP_BASE)
	) u_load_sequencer (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.crt_align_i      (crt_align),
		.crt_payload_i    (crt_payload),
		.slot_if          (u_slot_if.seq),
		.ioctl_wait_o     (ioctl_wait_o),
		.start_o          (start_o),
		.tap_len_o        (tap_len_o)
	);

	io_slot_writer u_io_slot_writer (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.io_cycle_i (io_cycle_i),
		.slot_if    (u_slot_if.slot),
		.mem_ce_o   (mem_ce_o),
		.mem_we_o   (mem_we_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o)
	);

endmodule

/* verif/tb_c64_loader.sv */
`timescale 1ns/10ps

module tb_c64_loader;
	import loader_pkg::*;

	localparam int        CLK_PERIOD = 100;
	localparam mem_addr_t CRT_REGION = 25'h100000;
	localparam mem_addr_t TAP_REGION = 25'h200000;

	// Zero page pointer map of the BASIC loader
	localparam mem_addr_t ZP_END_LO [4] = '{25'h2D, 25'h2F, 25'h31, 25'hAE};
	localparam mem_addr_t ZP_END_HI [4] = '{25'h2E, 25'h30, 25'h32, 25'hAF};

	typedef struct packed {
		dl_index_t   index;
		int          byte_first;
		int          byte_cnt;
		int          wr_first;
		int          wr_cnt;
		int          hdr_first;
		int          hdr_cnt;
		int          starts;
		logic [31:0] cart;
		mem_addr_t   tap_len;
	} dl_rec_t;

	logic      clk_sys;
	logic      RESET;
	logic      ioctl_download_i;
	logic      ioctl_wr_i;
	logic      io_cycle_i;
	dl_index_t ioctl_index_i;
	mem_addr_t ioctl_addr_i;
	byte_t     ioctl_data_i;
	logic      detach_i;
	logic      ioctl_wait_o;
	logic      mem_ce_o;
	logic      mem_we_o;
	logic      start_o;
	logic      cart_attached_o;
	logic      crt_hdr_wr_o;
	mem_addr_t mem_addr_o;
	byte_t     mem_data_o;
	word16_t   cart_id_o;
	word16_t   bank_num_o;
	word16_t   bank_laddr_o;
	word16_t   bank_size_o;
	byte_t     cart_exrom_o;
	byte_t     cart_game_o;
	byte_t     bank_type_o;
	mem_addr_t tap_len_o;

	// Download table and expected results
	dl_rec_t     downloads[$];
	string       rec_names[$];
	byte_t       pool[$];
	mem_addr_t   exp_addr[$];
	byte_t       exp_data[$];
	logic [55:0] exp_hdr[$];

	// Memory model and observed events
	byte_t       mem [mem_addr_t];
	logic [55:0] got_hdr[$];
	logic        ce_seen = 1'b0;
	int          write_cnt = 0;
	int          start_cnt = 0;
	int          errors = 0;
	int          io_cnt = 0;
	logic [15:0] lfsr_q = 16'd13;
	logic        table_ready = 1'b0;
	time         wd_limit;

	c64_loader_top #(
		.CRT_BASE (CRT_REGION),
		.TAP_BASE (TAP_REGION)
	) u_c64_loader_top (.*);

	// ==================================================
	// Clock, io slots and monitors
	// ==================================================

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// Slot pattern of 12 clocks, low half first
	always @(posedge clk_sys) begin
		#10;
		io_cnt     = (io_cnt == 11) ? 0 : io_cnt + 1;
		io_cycle_i = (io_cnt >= 6);
	end

	// Sampled mid cycle where all outputs are settled
	always @(negedge clk_sys) begin
		if (mem_ce_o && mem_we_o && !ce_seen) begin
			mem[mem_addr_o] = mem_data_o;
			write_cnt++;
		end
		ce_seen = mem_ce_o;
		if (start_o)
			start_cnt++;
		if (crt_hdr_wr_o)
			got_hdr.push_back({bank_type_o, bank_num_o, bank_laddr_o, bank_size_o});
	end

	initial begin
		wait (table_ready);
		wd_limit = (pool.size() + 600) * 24 * CLK_PERIOD;
		#(wd_limit);
		$display("Timeout: the downloads did not complete in the expected time");
		$display("*** FAILED ***");
		$finish;
	end

	// ==================================================
	// Helpers
	// ==================================================

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic byte_t rand_byte();
		byte_t b;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			b      = {b[6:0], lfsr_q[0]};
		end
		return b;
	endfunction

	task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("FAIL %0t: %s got %0h expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic add_expected(input mem_addr_t a, input byte_t d);
		exp_addr.push_back(a);
		exp_data.push_back(d);
	endtask

	function automatic dl_rec_t new_rec(input dl_index_t idx);
		dl_rec_t r;
		r            = '0;
		r.index      = idx;
		r.byte_first = pool.size();
		r.wr_first   = exp_addr.size();
		r.hdr_first  = exp_hdr.size();
		return r;
	endfunction

	task automatic close_rec(input dl_rec_t r, input string name);
		r.byte_cnt = pool.size() - r.byte_first;
		r.wr_cnt   = exp_addr.size() - r.wr_first;
		r.hdr_cnt  = exp_hdr.size() - r.hdr_first;
		downloads.push_back(r);
		rec_names.push_back(name);
	endtask

	// ==================================================
	// Table builders
	// ==================================================

	task automatic add_prg(input string name, input word16_t load, input int n);
		dl_rec_t r;
		byte_t   d;
		word16_t end_a;
		r = new_rec(IDX_PRG);
		r.starts = 1;
		pool.push_back(load[7:0]);
		pool.push_back(load[15:8]);
		for (int k = 0; k < n; k++) begin
			d = rand_byte();
			pool.push_back(d);
			add_expected(mem_addr_t'(load + k), d);
		end
		end_a = load + 16'(n);
		add_expected(25'h2B, 8'h01);
		add_expected(25'h2C, 8'h08);
		add_expected(25'hAC, 8'h00);
		add_expected(25'hAD, 8'h00);
		for (int i = 0; i < 4; i++) begin
			add_expected(ZP_END_LO[i], end_a[7:0]);
			add_expected(ZP_END_HI[i], end_a[15:8]);
		end
		close_rec(r, name);
	endtask

	task automatic add_crt(input string name, input word16_t id, input byte_t exrom,
		input byte_t game, input int nchips, input int plen);
		dl_rec_t      r;
		byte_t        d;
		byte_t        btype;
		logic [127:0] chip;
		r = new_rec(IDX_CRT);
		r.cart = {id, exrom, game};
		for (int o = 0; o < 64; o++) begin
			case (o)
				'h16: pool.push_back(id[15:8]);
				'h17: pool.push_back(id[7:0]);
				'h18: pool.push_back(exrom);
				'h19: pool.push_back(game);
				default: pool.push_back(8'h00);
			endcase
		end
		for (int c = 0; c < nchips; c++) begin
			btype = (c == 0) ? 8'h00 : 8'h02;
			// CHIP tag, packet length, type, bank, load address, size
			chip = {32'h43484950, 32'(16 + plen), 8'h00, btype, 16'(c),
				c[0] ? 16'hA000 : 16'h8000, 16'(plen)};
			for (int b = 15; b >= 0; b--)
				pool.push_back(chip[b * 8 +: 8]);
			exp_hdr.push_back({btype, 16'(c), c[0] ? 16'hA000 : 16'h8000, 16'(plen)});
			for (int k = 0; k < plen; k++) begin
				d = rand_byte();
				pool.push_back(d);
				add_expected(CRT_REGION + mem_addr_t'(c * 32'h2000 + k), d);
			end
		end
		close_rec(r, name);
	endtask

	task automatic add_tap(input string name, input int n);
		dl_rec_t r;
		byte_t   d;
		r = new_rec(IDX_TAP);
		for (int k = 0; k < n; k++) begin
			d = rand_byte();
			pool.push_back(d);
			add_expected(TAP_REGION + mem_addr_t'(k), d);
		end
		r.tap_len = mem_addr_t'(n + 1);
		close_rec(r, name);
	endtask

	// ==================================================
	// Host side
	// ==================================================

	task automatic wait_ready();
		while (ioctl_wait_o)
			next_cycle();
	endtask

	task automatic send_byte(input int ofs, input byte_t d);
		wait_ready();
		ioctl_wr_i   = 1'b1;
		ioctl_addr_i = mem_addr_t'(ofs);
		ioctl_data_i = d;
		next_cycle();
		ioctl_wr_i = 1'b0;
	endtask

	task automatic wait_start(input int base);
		int n;
		n = 0;
		while ((start_cnt == base) && (n < 4000)) begin
			next_cycle();
			n++;
		end
		if (start_cnt == base) begin
			$display("Time %0t: no start pulse after the PRG download", $time);
			errors++;
		end
	endtask

	task automatic verify_download(input dl_rec_t r, input int start_base);
		mem_addr_t a;
		for (int j = r.wr_first; j < r.wr_first + r.wr_cnt; j++) begin
			a = exp_addr[j];
			if (!mem.exists(a)) begin
				$display("Time %0t: no memory write seen at address %h", $time, a);
				errors++;
			end else begin
				check_equal(64'(mem[a]), 64'(exp_data[j]), $sformatf("memory at %h", a));
			end
		end
		check_equal(64'(write_cnt), 64'(r.wr_cnt), "memory write count");
		check_equal(64'(start_cnt - start_base), 64'(r.starts), "start pulse count");
		check_equal(64'(got_hdr.size()), 64'(r.hdr_cnt), "chip header count");
		for (int h = 0; (h < r.hdr_cnt) && (h < got_hdr.size()); h++)
			check_equal(64'(got_hdr[h]), 64'(exp_hdr[r.hdr_first + h]),
				$sformatf("chip %0d bank fields", h));
		if (r.index == IDX_CRT)
			check_equal(64'({cart_id_o, cart_exrom_o, cart_game_o}), 64'(r.cart),
				"cartridge header fields");
		if (r.index == IDX_TAP)
			check_equal(64'(tap_len_o), 64'(r.tap_len), "tape length");
	endtask

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin
		dl_rec_t r;
		int      start_base;
		int      errs_before;
		int      failed_tests;
		clk_sys          = 1'b0;
		RESET            = 1'b1;
		ioctl_download_i = 1'b0;
		ioctl_wr_i       = 1'b0;
		io_cycle_i       = 1'b0;
		ioctl_index_i    = '0;
		ioctl_addr_i     = '0;
		ioctl_data_i     = '0;
		detach_i         = 1'b0;
		failed_tests     = 0;

		add_prg("prg_basic", 16'h0801, 40);
		add_crt("crt_three_chips", 16'h0013, 8'h00, 8'h01, 3, 24);
		add_tap("tap_image", 50);
		add_prg("prg_page_cross", 16'h1FF0, 32);
		table_ready = 1'b1;

		repeat (3) @(posedge clk_sys);
		#10;
		RESET = 1'b0;
		next_cycle();
		check_equal(64'({mem_ce_o, mem_we_o, ioctl_wait_o, start_o, crt_hdr_wr_o,
			cart_attached_o}), 64'd0, "outputs after reset");

		foreach (downloads[t]) begin
			r           = downloads[t];
			errs_before = errors;
			start_base  = start_cnt;
			write_cnt   = 0;
			mem.delete();
			got_hdr.delete();

			ioctl_index_i    = r.index;
			ioctl_download_i = 1'b1;
			next_cycle();
			for (int i = 0; i < r.byte_cnt; i++)
				send_byte(i, pool[r.byte_first + i]);
			wait_ready();
			ioctl_download_i = 1'b0;
			if (r.starts > 0)
				wait_start(start_base);
			repeat (16) next_cycle();
			verify_download(r, start_base);

			// Cartridge stays attached until detach
			if (r.index == IDX_CRT) begin
				check_equal(64'(cart_attached_o), 64'd1, "attached after CRT download");
				detach_i = 1'b1;
				next_cycle();
				detach_i = 1'b0;
				repeat (2) next_cycle();
				check_equal(64'(cart_attached_o), 64'd0, "attached after detach");
			end

			if (errors == errs_before) begin
				$display("Test %0d %s: passed", t, rec_names[t]);
			end else begin
				$display("Test %0d %s: failed", t, rec_names[t]);
				failed_tests++;
			end
		end

		$display("Summary: %0d tests, %0d failed, %0d check errors",
			downloads.size(), failed_tests, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* all.f */
hdl/loader_pkg.sv
hdl/mem_slot_if.sv
hdl/crt_header_regs.sv
hdl/load_sequencer.sv
hdl/io_slot_writer.sv
hdl/c64_loader_top.sv
verif/tb_c64_loader.sv

/* Makefile */
# Verilator build and run of the loader testbench

VERILATOR ?= verilator
TOP       ?= tb_c64_loader
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard hdl/*.sv) $(wildcard verif/*.sv)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qF -- '*** PASSED ***' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
